/* dv/mem_subsys_tb.sv */
// Memory subsystem testbench
// Table-driven stimulus in place of the execute stage, with a byte-level
// memory model and an in-order queue of expected writebacks

`timescale 1ns/1ns

module mem_subsys_tb import mem_pkg::*; ();

    typedef struct {
        string             name;
        inst_class_e       cls;
        ls_width_e         w;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   alu;     // ALU value or load/store byte address
        logic [XLEN-1:0]   sd;
        logic [XLEN-1:0]   pc;
        int                hold;    // Cycles of wb_stall_i while this entry waits
    } entry_t;

    typedef struct {
        string             name;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
        logic [XLEN-1:0]   pc;
    } wb_t;

    logic              clk = 1'b0;
    logic              rst_n_i;
    inst_class_e       ex_class_i;
    logic              ex_rd_ena_i;
    logic [REG_AW-1:0] ex_rd_addr_i;
    logic [XLEN-1:0]   ex_rd_data_i;
    logic [XLEN-1:0]   ex_st_data_i;
    ls_width_e         ex_ls_width_i;
    logic [XLEN-1:0]   ex_pc_i;
    logic [XLEN-1:0]   ex_inst_i;
    logic              wb_stall_i;
    logic              stall_o;
    logic              wb_rd_ena_o;
    logic [REG_AW-1:0] wb_rd_addr_o;
    logic [XLEN-1:0]   wb_rd_data_o;
    logic [XLEN-1:0]   wb_pc_o;

    entry_t            tbl[$];
    wb_t               exp_q[$];
    logic [7:0]        mem_model [1024];
    int                seed;
    int                n_loads = 0;
    int                total_hold = 0;
    int                load_stalls = 0;
    bit                table_built = 1'b0;
    bit                hold_prev = 1'b0;
    bit                load_stall_prev = 1'b0;
    logic              snap_ena;
    logic [REG_AW-1:0] snap_rd;
    logic [XLEN-1:0]   snap_data;
    logic [XLEN-1:0]   snap_pc;

    always #10 clk = ~clk;

    mem_subsys_top DUT (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .ex_class_i    (ex_class_i),
        .ex_rd_ena_i   (ex_rd_ena_i),
        .ex_rd_addr_i  (ex_rd_addr_i),
        .ex_rd_data_i  (ex_rd_data_i),
        .ex_st_data_i  (ex_st_data_i),
        .ex_ls_width_i (ex_ls_width_i),
        .ex_pc_i       (ex_pc_i),
        .ex_inst_i     (ex_inst_i),
        .wb_stall_i    (wb_stall_i),
        .stall_o       (stall_o),
        .wb_rd_ena_o   (wb_rd_ena_o),
        .wb_rd_addr_o  (wb_rd_addr_o),
        .wb_rd_data_o  (wb_rd_data_o),
        .wb_pc_o       (wb_pc_o)
    );

    task automatic value_mismatch(input string name, input logic [XLEN-1:0] exp_v,
                                  input logic [XLEN-1:0] act_v);
        $display("CHECK FAILED %s expected 0x%08h actual 0x%08h", name, exp_v, act_v);
        $display("TEST FAIL");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic abort_run(input string msg);
        $display("ERROR: %s", msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic add_entry(input string name, input inst_class_e cls, input ls_width_e w,
                             input logic [REG_AW-1:0] rd, input logic [XLEN-1:0] alu,
                             input logic [XLEN-1:0] sd, input int hold);
        entry_t e;
        e.name = name;
        e.cls  = cls;
        e.w    = w;
        e.rd   = rd;
        e.alu  = alu;
        e.sd   = sd;
        e.pc   = 32'h1000 + 32'(tbl.size() * 4);
        e.hold = hold;
        tbl.push_back(e);
        if (cls == INST_LOAD) n_loads++;
        total_hold += hold;
    endtask

    task automatic build_table();
        logic [XLEN-1:0] sd;
        add_entry("alu a", INST_ALU, LS_W, 5'd1, $random(seed), '0, 0);
        add_entry("alu b", INST_ALU, LS_W, 5'd2, $random(seed), '0, 0);
        add_entry("alu c", INST_ALU, LS_W, 5'd3, $random(seed), '0, 0);
        add_entry("sw word", INST_STORE, LS_W, 5'd0, 32'h40, $random(seed), 0);
        add_entry("lw word", INST_LOAD, LS_W, 5'd4, 32'h40, '0, 0);
        // Byte lanes, even offsets get a negative byte
        add_entry("sw byte base", INST_STORE, LS_W, 5'd0, 32'h80, $random(seed), 0);
        for (int off = 0; off < 4; off++) begin
            sd = $random(seed);
            sd[7] = (off % 2 == 0);
            add_entry($sformatf("sb off %0d", off), INST_STORE, LS_B, 5'd0,
                      32'h80 + 32'(off), sd, 0);
        end
        for (int off = 0; off < 4; off++) begin
            add_entry($sformatf("lb off %0d", off), INST_LOAD, LS_B, 5'(8 + off),
                      32'h80 + 32'(off), '0, 0);
            add_entry($sformatf("lbu off %0d", off), INST_LOAD, LS_BU, 5'(12 + off),
                      32'h80 + 32'(off), '0, 0);
        end
        // Halfword lanes, the lower one negative
        add_entry("sw half base", INST_STORE, LS_W, 5'd0, 32'hC0, $random(seed), 0);
        for (int off = 0; off < 4; off += 2) begin
            sd = $random(seed);
            sd[15] = (off == 0);
            add_entry($sformatf("sh off %0d", off), INST_STORE, LS_H, 5'd0,
                      32'hC0 + 32'(off), sd, 0);
        end
        for (int off = 0; off < 4; off += 2) begin
            add_entry($sformatf("lh off %0d", off), INST_LOAD, LS_H, 5'(16 + off),
                      32'hC0 + 32'(off), '0, 0);
            add_entry($sformatf("lhu off %0d", off), INST_LOAD, LS_HU, 5'(17 + off),
                      32'hC0 + 32'(off), '0, 0);
        end
        // Writeback back-pressure over a result, a store and a waiting load
        add_entry("alu before hold", INST_ALU, LS_W, 5'd20, $random(seed), '0, 0);
        add_entry("alu under hold", INST_ALU, LS_W, 5'd21, $random(seed), '0, 3);
        add_entry("sw held", INST_STORE, LS_W, 5'd0, 32'h100, $random(seed), 0);
        add_entry("alu after store", INST_ALU, LS_W, 5'd22, $random(seed), '0, 4);
        add_entry("lw held store", INST_LOAD, LS_W, 5'd23, 32'h100, '0, 0);
        add_entry("lw again", INST_LOAD, LS_W, 5'd24, 32'h40, '0, 0);
        add_entry("alu under load", INST_ALU, LS_W, 5'd25, $random(seed), '0, 2);
        add_entry("alu last", INST_ALU, LS_W, 5'd26, $random(seed), '0, 0);
    endtask

    task automatic drive_entry(input entry_t e);
        ex_class_i    = e.cls;
        ex_rd_ena_i   = (e.cls == INST_ALU || e.cls == INST_LOAD);
        ex_rd_addr_i  = e.rd;
        ex_rd_data_i  = e.alu;
        ex_st_data_i  = e.sd;
        ex_ls_width_i = e.w;
        ex_pc_i       = e.pc;
        ex_inst_i     = ~e.pc;              // Tag only
    endtask

    task automatic idle_inputs();
        ex_class_i    = INST_NOP;
        ex_rd_ena_i   = 1'b0;
        ex_rd_addr_i  = '0;
        ex_rd_data_i  = '0;
        ex_st_data_i  = '0;
        ex_ls_width_i = LS_W;
        ex_pc_i       = '0;
        ex_inst_i     = '0;
    endtask

    // Little-endian byte memory, as many bytes as the width asks for
    task automatic apply_store(input logic [XLEN-1:0] addr, input ls_width_e w,
                               input logic [XLEN-1:0] data);
        int nb;
        int base;
        nb = (w == LS_W) ? 4 : ((w == LS_H || w == LS_HU) ? 2 : 1);
        base = int'(addr[9:0]);
        for (int i = 0; i < nb; i++) begin
            mem_model[base + i] = data[8*i +: 8];
        end
    endtask

    function automatic logic [XLEN-1:0] expected_load(input logic [XLEN-1:0] addr,
                                                      input ls_width_e w);
        int              base;
        logic [XLEN-1:0] raw;
        base = int'(addr[9:0]);
        raw  = '0;
        case (w)
            LS_B, LS_BU: raw[7:0]  = mem_model[base];
            LS_H, LS_HU: raw[15:0] = {mem_model[base + 1], mem_model[base]};
            default:     raw = {mem_model[base + 3], mem_model[base + 2],
                                mem_model[base + 1], mem_model[base]};
        endcase
        case (w)
            LS_B:    return {{24{raw[7]}}, raw[7:0]};
            LS_H:    return {{16{raw[15]}}, raw[15:0]};
            default: return raw;                    // Zero extended or full word
        endcase
    endfunction

    task automatic record_issue(input entry_t e);
        wb_t r;
        r.name = e.name;
        r.rd   = e.rd;
        r.pc   = e.pc;
        case (e.cls)
            INST_STORE: apply_store(e.alu, e.w, e.sd);
            INST_LOAD: begin
                r.data = expected_load(e.alu, e.w);
                exp_q.push_back(r);
            end
            INST_ALU: begin
                r.data = e.alu;
                exp_q.push_back(r);
            end
            default: ;
        endcase
    endtask

    initial begin : main
        int hold_left;
        bit taken;
        seed       = 90;
        rst_n_i    = 1'b0;
        wb_stall_i = 1'b0;
        idle_inputs();
        build_table();
        table_built = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        @(negedge clk);
        assert (wb_rd_ena_o == 1'b0)
            else value_mismatch("reset wb_rd_ena_o", '0, 32'(wb_rd_ena_o));
        assert (stall_o == 1'b0)
            else value_mismatch("reset stall_o", '0, 32'(stall_o));
        @(posedge clk);
        #2;
        for (int k = 0; k < tbl.size(); k++) begin
            drive_entry(tbl[k]);
            hold_left  = tbl[k].hold;
            wb_stall_i = (hold_left > 0);
            taken      = 1'b0;
            // Entry is taken at the edge that follows a low stall_o
            while (!taken) begin
                @(negedge clk);
                taken = !stall_o;
                @(posedge clk);
                #2;
                if (hold_left > 0) hold_left--;
                wb_stall_i = (hold_left > 0);
            end
            record_issue(tbl[k]);
        end
        idle_inputs();
        while (exp_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);                  // Room for a duplicate to show up
        if (load_stalls == n_loads) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("ERROR: %0d load stall cycles for %0d loads", load_stalls, n_loads);
            $display("TEST FAIL");
            $fatal(1, "end of run checks failed");
        end
    end

    always @(negedge clk) begin : monitor
        wb_t e;
        if (rst_n_i) begin
            if (hold_prev) begin
                assert (wb_rd_ena_o == snap_ena)
                    else value_mismatch("hold wb_rd_ena_o", 32'(snap_ena), 32'(wb_rd_ena_o));
                assert (wb_rd_addr_o == snap_rd)
                    else value_mismatch("hold wb_rd_addr_o", 32'(snap_rd), 32'(wb_rd_addr_o));
                assert (wb_rd_data_o == snap_data)
                    else value_mismatch("hold wb_rd_data_o", snap_data, wb_rd_data_o);
                assert (wb_pc_o == snap_pc)
                    else value_mismatch("hold wb_pc_o", snap_pc, wb_pc_o);
            end
            if (wb_stall_i) begin
                assert (stall_o) else abort_run("stall_o was low while writeback was stalled");
            end
            if (stall_o && !wb_stall_i) begin
                load_stalls++;
                assert (!load_stall_prev)
                    else abort_run("stall_o stayed high for more than one cycle on a load");
            end
            load_stall_prev = stall_o && !wb_stall_i;
            // The register file takes a result at an edge without back-pressure
            if (wb_rd_ena_o && !wb_stall_i) begin
                assert (exp_q.size() != 0) else abort_run("writeback seen with no result pending");
                e = exp_q.pop_front();
                assert (wb_rd_addr_o == e.rd)
                    else value_mismatch({e.name, " rd_addr"}, 32'(e.rd), 32'(wb_rd_addr_o));
                assert (wb_rd_data_o == e.data)
                    else value_mismatch({e.name, " rd_data"}, e.data, wb_rd_data_o);
                assert (wb_pc_o == e.pc)
                    else value_mismatch({e.name, " pc"}, e.pc, wb_pc_o);
            end
            hold_prev = wb_stall_i;
            snap_ena  = wb_rd_ena_o;
            snap_rd   = wb_rd_addr_o;
            snap_data = wb_rd_data_o;
            snap_pc   = wb_pc_o;
        end
    end

    initial begin : watchdog
        int limit;
        wait (table_built);
        limit = 5 + tbl.size() * 4 + total_hold + 20;
        repeat (limit) @(posedge clk);
        $display("ERROR: timeout after %0d cycles, the writebacks did not complete", limit);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the memory subsystem testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 -f sources.f --top-module mem_subsys_tb \
    -o mem_subsys_sim &&
./obj_dir/mem_subsys_sim | tee /dev/stderr | grep -qx "TEST PASS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* sources.f */
src/mem_pkg.sv
src/ex_mem_if.sv
src/ex_mem.sv
src/lsu.sv
src/data_ram.sv
src/stall_ctrl.sv
src/mem_wb.sv
src/mem_subsys_top.sv
dv/mem_subsys_tb.sv

/* src/data_ram.sv */
// Data RAM
// Single-port word memory with byte-lane write enables and a registered read

`timescale 1ns/1ns

module data_ram import mem_pkg::*; (
    input  logic              clk,
    input  logic [RAM_AW-1:0] addr_i,
    input  logic [NBYTES-1:0] we_i,
    input  logic [XLEN-1:0]   wdata_i,
    output logic [XLEN-1:0]   rdata_o
);

    logic [XLEN-1:0] mem [2**RAM_AW];

    always_ff @(posedge clk) begin
        for (int b = 0; b < NBYTES; b++) begin
            if (we_i[b]) begin
                mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
            end
        end
        rdata_o <= mem[addr_i];                 // Old data on a same-cycle write
    end

endmodule

/* src/ex_mem.sv */
// Execute-to-memory pipeline register
// Loads the execute results every cycle unless the stall vector holds
// the execute stage and everything upstream of it

`timescale 1ns/1ns

module ex_mem import mem_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic     [STALL_W-1:0] stall_i,
    input  inst_class_e            ex_class_i,
    input  logic                   ex_rd_ena_i,
    input  logic     [REG_AW-1:0]  ex_rd_addr_i,
    input  logic     [XLEN-1:0]    ex_rd_data_i,
    input  logic     [XLEN-1:0]    ex_st_data_i,
    input  ls_width_e              ex_ls_width_i,
    input  logic     [XLEN-1:0]    ex_pc_i,
    input  logic     [XLEN-1:0]    ex_inst_i,
    ex_mem_if.producer             exm_o
);

    logic hold;

    // Hold only when bits 0 to 3 are all set
    assign hold = &stall_i[STALL_EX:STALL_PC];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exm_o.inst_class <= INST_NOP;
            exm_o.rd_ena     <= 1'b0;
            exm_o.rd_addr    <= '0;
            exm_o.rd_data    <= '0;
            exm_o.st_data    <= '0;
            exm_o.ls_width   <= LS_W;
            exm_o.pc         <= '0;
            exm_o.inst       <= '0;
        end else if (!hold) begin
            exm_o.inst_class <= ex_class_i;
            exm_o.rd_ena     <= ex_rd_ena_i;
            exm_o.rd_addr    <= ex_rd_addr_i;
            exm_o.rd_data    <= ex_rd_data_i;
            exm_o.st_data    <= ex_st_data_i;
            exm_o.ls_width   <= ex_ls_width_i;
            exm_o.pc         <= ex_pc_i;
            exm_o.inst       <= ex_inst_i;
        end
    end

    // Writeback back-pressure must also freeze this stage, or an entry is lost
    a_mem_stall_holds_ex: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        stall_i[STALL_MEM] |-> stall_i[STALL_EX]
    );

endmodule

/* src/ex_mem_if.sv */
// Execute-to-memory bundle
// Carries the latched execute results from the pipeline register
// to the load/store unit

`timescale 1ns/1ns

interface ex_mem_if import mem_pkg::*; ();

    inst_class_e              inst_class;
    logic                     rd_ena;
    logic        [REG_AW-1:0] rd_addr;
    logic        [XLEN-1:0]   rd_data;   // ALU result, also the load/store address
    logic        [XLEN-1:0]   st_data;
    ls_width_e                ls_width;
    logic        [XLEN-1:0]   pc;
    logic        [XLEN-1:0]   inst;

    modport producer (
        output inst_class, rd_ena, rd_addr, rd_data, st_data, ls_width, pc, inst
    );

    modport consumer (
        input  inst_class, rd_ena, rd_addr, rd_data, st_data, ls_width, pc, inst
    );

endinterface

/* src/lsu.sv */
// Load/store unit
// Drives the data RAM from the latched execute results, places store bytes
// in their lanes and extends load data; a load waits one cycle for the RAM

`timescale 1ns/1ns

module lsu import mem_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic [STALL_W-1:0]  stall_i,
    ex_mem_if.consumer          exm_i,
    output logic [RAM_AW-1:0]   ram_addr_o,
    output logic [NBYTES-1:0]   ram_we_o,
    output logic [XLEN-1:0]     ram_wdata_o,
    input  logic [XLEN-1:0]     ram_rdata_i,
    output logic                mem_stall_req_o,
    output logic                res_rd_ena_o,
    output logic [REG_AW-1:0]   res_rd_addr_o,
    output logic [XLEN-1:0]     res_rd_data_o,
    output logic [XLEN-1:0]     res_pc_o
);

    logic              is_load;
    logic              is_store;
    logic [1:0]        lane;
    logic              load_wait;
    logic [NBYTES-1:0] byte_en;
    logic [XLEN-1:0]   rdata_sh;
    logic [XLEN-1:0]   load_data;
    logic              misaligned;

    assign is_load  = (exm_i.inst_class == INST_LOAD);
    assign is_store = (exm_i.inst_class == INST_STORE);
    assign lane     = exm_i.rd_data[1:0];

    assign ram_addr_o = exm_i.rd_data[RAM_AW+1:2];

    // Store lane placement
    always_comb begin
        case (exm_i.ls_width)
            LS_B, LS_BU: begin
                ram_wdata_o = {NBYTES{exm_i.st_data[7:0]}};
                byte_en     = 4'b0001 << lane;
            end
            LS_H, LS_HU: begin
                ram_wdata_o = {(NBYTES/2){exm_i.st_data[15:0]}};
                byte_en     = 4'b0011 << lane;
            end
            default: begin
                ram_wdata_o = exm_i.st_data;
                byte_en     = '1;
            end
        endcase
    end

    // No write while writeback is stalled, the store stays and retries later
    assign ram_we_o = (is_store && !stall_i[STALL_MEM]) ? byte_en : '0;

    // First load cycle issues the read and asks for a stall
    assign mem_stall_req_o = is_load && !load_wait;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            load_wait <= 1'b0;
        end else if (!stall_i[STALL_MEM]) begin
            load_wait <= mem_stall_req_o;
        end
    end

    // Lane select and extension of the returned word
    assign rdata_sh = ram_rdata_i >> {lane, 3'b000};

    always_comb begin
        case (exm_i.ls_width)
            LS_B:    load_data = {{(XLEN-8){rdata_sh[7]}}, rdata_sh[7:0]};
            LS_BU:   load_data = {{(XLEN-8){1'b0}}, rdata_sh[7:0]};
            LS_H:    load_data = {{(XLEN-16){rdata_sh[15]}}, rdata_sh[15:0]};
            LS_HU:   load_data = {{(XLEN-16){1'b0}}, rdata_sh[15:0]};
            default: load_data = rdata_sh;
        endcase
    end

    // Stores never write back, a load only once its data is back
    always_comb begin
        case (exm_i.inst_class)
            INST_ALU:  res_rd_ena_o = exm_i.rd_ena;
            INST_LOAD: res_rd_ena_o = exm_i.rd_ena && load_wait;
            default:   res_rd_ena_o = 1'b0;
        endcase
    end

    assign res_rd_addr_o = exm_i.rd_addr;
    assign res_rd_data_o = is_load ? load_data : exm_i.rd_data;
    assign res_pc_o      = exm_i.pc;

    always_comb begin
        case (exm_i.ls_width)
            LS_H, LS_HU: misaligned = lane[0];
            LS_W:        misaligned = |lane;
            default:     misaligned = 1'b0;
        endcase
    end

    a_aligned: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (is_load || is_store) |-> !misaligned
    );

endmodule

/* src/mem_pkg.sv */
// Memory stage package
// Data widths, instruction-class and load/store-width encodings,
// and bit positions of the pipeline stall vector

package mem_pkg;

    // Datapath widths
    localparam int XLEN   = 32;
    localparam int REG_AW = 5;
    localparam int RAM_AW = 8;              // 256 words
    localparam int NBYTES = XLEN / 8;       // Byte lanes per word

    // Stall vector, one bit per pipeline register
    localparam int STALL_W   = 5;
    localparam int STALL_PC  = 0;
    localparam int STALL_IF  = 1;
    localparam int STALL_ID  = 2;
    localparam int STALL_EX  = 3;           // Holds ex_mem
    localparam int STALL_MEM = 4;           // Holds mem_wb

    // Instruction class seen by the memory stage
    typedef enum logic [1:0] {
        INST_ALU   = 2'd0,
        INST_LOAD  = 2'd1,
        INST_STORE = 2'd2,
        INST_NOP   = 2'd3
    } inst_class_e;

    // Load/store width, same code as RISC-V funct3
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_BU = 3'b100,
        LS_HU = 3'b101
    } ls_width_e;

endpackage

/* src/mem_subsys_top.sv */
// Memory subsystem top
// Execute-to-memory register, load/store unit, data RAM, stall control
// and memory-to-writeback register

`timescale 1ns/1ns

module mem_subsys_top import mem_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  inst_class_e         ex_class_i,
    input  logic                ex_rd_ena_i,
    input  logic [REG_AW-1:0]   ex_rd_addr_i,
    input  logic [XLEN-1:0]     ex_rd_data_i,
    input  logic [XLEN-1:0]     ex_st_data_i,
    input  ls_width_e           ex_ls_width_i,
    input  logic [XLEN-1:0]     ex_pc_i,
    input  logic [XLEN-1:0]     ex_inst_i,
    input  logic                wb_stall_i,
    output logic                stall_o,
    output logic                wb_rd_ena_o,
    output logic [REG_AW-1:0]   wb_rd_addr_o,
    output logic [XLEN-1:0]     wb_rd_data_o,
    output logic [XLEN-1:0]     wb_pc_o
);

    logic [STALL_W-1:0] stall_vec;
    logic               mem_stall_req;
    logic [RAM_AW-1:0]  ram_addr;
    logic [NBYTES-1:0]  ram_we;
    logic [XLEN-1:0]    ram_wdata;
    logic [XLEN-1:0]    ram_rdata;
    logic               res_rd_ena;
    logic [REG_AW-1:0]  res_rd_addr;
    logic [XLEN-1:0]    res_rd_data;
    logic [XLEN-1:0]    res_pc;

    ex_mem_if u_exm_if ();

    ex_mem u_ex_mem (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_vec),
        .ex_class_i    (ex_class_i),
        .ex_rd_ena_i   (ex_rd_ena_i),
        .ex_rd_addr_i  (ex_rd_addr_i),
        .ex_rd_data_i  (ex_rd_data_i),
        .ex_st_data_i  (ex_st_data_i),
        .ex_ls_width_i (ex_ls_width_i),
        .ex_pc_i       (ex_pc_i),
        .ex_inst_i     (ex_inst_i),
        .exm_o         (u_exm_if.producer)
    );

    lsu u_lsu (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .stall_i         (stall_vec),
        .exm_i           (u_exm_if.consumer),
        .ram_addr_o      (ram_addr),
        .ram_we_o        (ram_we),
        .ram_wdata_o     (ram_wdata),
        .ram_rdata_i     (ram_rdata),
        .mem_stall_req_o (mem_stall_req),
        .res_rd_ena_o    (res_rd_ena),
        .res_rd_addr_o   (res_rd_addr),
        .res_rd_data_o   (res_rd_data),
        .res_pc_o        (res_pc)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .addr_i  (ram_addr),
        .we_i    (ram_we),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    stall_ctrl u_stall_ctrl (
        .mem_stall_req_i  (mem_stall_req),
        .wb_stall_i       (wb_stall_i),
        .stall_o          (stall_vec),
        .upstream_stall_o (stall_o)
    );

    mem_wb u_mem_wb (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_vec),
        .res_rd_ena_i  (res_rd_ena),
        .res_rd_addr_i (res_rd_addr),
        .res_rd_data_i (res_rd_data),
        .res_pc_i      (res_pc),
        .wb_rd_ena_o   (wb_rd_ena_o),
        .wb_rd_addr_o  (wb_rd_addr_o),
        .wb_rd_data_o  (wb_rd_data_o),
        .wb_pc_o       (wb_pc_o)
    );

endmodule

/* src/mem_wb.sv */
// Memory-to-writeback pipeline register
// Holds under back-pressure and inserts a bubble while a load waits

`timescale 1ns/1ns

module mem_wb import mem_pkg::*; (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic [STALL_W-1:0] stall_i,
    input  logic               res_rd_ena_i,
    input  logic [REG_AW-1:0]  res_rd_addr_i,
    input  logic [XLEN-1:0]    res_rd_data_i,
    input  logic [XLEN-1:0]    res_pc_i,
    output logic               wb_rd_ena_o,
    output logic [REG_AW-1:0]  wb_rd_addr_o,
    output logic [XLEN-1:0]    wb_rd_data_o,
    output logic [XLEN-1:0]    wb_pc_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_rd_ena_o  <= 1'b0;
            wb_rd_addr_o <= '0;
            wb_rd_data_o <= '0;
            wb_pc_o      <= '0;
        end else if (stall_i[STALL_MEM]) begin
            // Hold everything
        end else if (stall_i[STALL_EX]) begin
            wb_rd_ena_o  <= 1'b0;               // Bubble
        end else begin
            wb_rd_ena_o  <= res_rd_ena_i;
            wb_rd_addr_o <= res_rd_addr_i;
            wb_rd_data_o <= res_rd_data_i;
            wb_pc_o      <= res_pc_i;
        end
    end

endmodule

/* src/stall_ctrl.sv */
// Stall controller
// Builds the five-bit stall vector from writeback back-pressure and the
// load stall request of the memory stage

`timescale 1ns/1ns

module stall_ctrl import mem_pkg::*; (
    input  logic               mem_stall_req_i,
    input  logic               wb_stall_i,
    output logic [STALL_W-1:0] stall_o,
    output logic               upstream_stall_o
);

    always_comb begin
        if (wb_stall_i) begin
            stall_o = '1;                       // Freeze the whole pipe
        end else if (mem_stall_req_i) begin
            stall_o = '0;
            stall_o[STALL_EX:STALL_PC] = '1;
        end else begin
            stall_o = '0;
        end
    end

    assign upstream_stall_o = |stall_o[STALL_ID:STALL_PC];

endmodule
